/* color_proc_defs.svh */
// color filter engine, global image parameters
// frame size, excluded border and histogram layout for the
// QQVGA RGB444 frame buffer
`ifndef COLOR_PROC_DEFS_SVH
`define COLOR_PROC_DEFS_SVH

`default_nettype none

// image size in pixels
`define IMG_COLS 160
`define IMG_ROWS 120

// columns and rows left out at each side of the image
// inner frame is cols 16..143, rows 8..111
`define BORDER_COLS 16
`define BORDER_ROWS 8

// histogram bins across the inner frame columns
`define HIST_BINS 8

// bits per color component in a buffer word
`define COMP_BITS 4

`default_nettype wire

`endif

/* color_pkg.sv */
// color types for the filter engine
// buffer pixel word and the eight filter modes
`include "color_proc_defs.svh"
`default_nettype none

package color_pkg;

  // one color component
  typedef logic [`COMP_BITS-1:0] comp_t;

  // buffer word, red in the high nibble, then green, blue in the low nibble
  typedef logic [3*`COMP_BITS-1:0] pixel_t;

  // filter mode, value bits are R, G, B
  // a set bit names a component that has to be high
  typedef enum logic [2:0] {
    MODE_NONE    = 3'b000,
    MODE_RED     = 3'b100,
    MODE_GREEN   = 3'b010,
    MODE_BLUE    = 3'b001,
    MODE_YELLOW  = 3'b110,
    MODE_MAGENTA = 3'b101,
    MODE_CYAN    = 3'b011,
    MODE_WHITE   = 3'b111
  } color_mode_e;

endpackage

`default_nettype wire

/* frame_pkg.sv */
// frame geometry and histogram types
// address, row and column types plus the bin count layout
`include "color_proc_defs.svh"
`default_nettype none

package frame_pkg;

  // frame and inner frame sizes
  localparam int IMG_PXLS   = `IMG_COLS * `IMG_ROWS;
  localparam int INNER_COLS = `IMG_COLS - 2 * `BORDER_COLS;
  localparam int INNER_ROWS = `IMG_ROWS - 2 * `BORDER_ROWS;
  localparam int BIN_COLS   = INNER_COLS / `HIST_BINS;

  // widths derived from the geometry
  localparam int PXL_ADDR_W  = $clog2(IMG_PXLS);
  localparam int COL_W       = $clog2(`IMG_COLS);
  localparam int ROW_W       = $clog2(`IMG_ROWS);
  localparam int BIN_IDX_W   = $clog2(`HIST_BINS);
  // bin index sits right above these inner column bits
  localparam int BIN_SHIFT   = $clog2(BIN_COLS);
  // 1664 per bin, 13312 in total
  localparam int BIN_CNT_W   = $clog2(BIN_COLS * INNER_ROWS + 1);
  localparam int TOTAL_CNT_W = $clog2(INNER_COLS * INNER_ROWS + 1);

  typedef logic [PXL_ADDR_W-1:0]  pxl_addr_t;
  typedef logic [COL_W-1:0]       col_t;
  typedef logic [ROW_W-1:0]       row_t;
  typedef logic [BIN_IDX_W-1:0]   bin_idx_t;
  typedef logic [BIN_CNT_W-1:0]   bin_cnt_t;
  typedef logic [TOTAL_CNT_W-1:0] total_cnt_t;
  typedef logic [`HIST_BINS-1:0][BIN_CNT_W-1:0] hist_t;

endpackage

`default_nettype wire

/* frame_scanner.sv */
// frame scanner
// walks the source buffer in raster order once per new frame,
// tracks row and column, decodes inner frame and bin, and
// delays the write address and flags to the classifier output stage
`timescale 1ns/1ps
`include "color_proc_defs.svh"
`default_nettype none

module frame_scanner import frame_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      new_frame_i,
  output pxl_addr_t orig_addr_o,
  output logic      pxl_valid_o,
  output pxl_addr_t proc_addr_o,
  output logic      proc_we_o,
  output logic      in_frame_o,
  output bin_idx_t  bin_idx_o,
  output logic      last_pxl_o
);

  // stage 0, address on the read port
  logic      busy;
  pxl_addr_t cnt_pxl;
  col_t      col;
  row_t      row;
  logic      end_pxl;
  logic      end_ln;
  col_t      col_inner;
  logic      in_frame_s0;
  logic      last_s0;
  bin_idx_t  bin_s0;

  // stage 1, read data is back
  logic      valid_s1;
  logic      in_frame_s1;
  logic      last_s1;
  pxl_addr_t addr_s1;
  bin_idx_t  bin_s1;

  // stage 2, classifier result is registered
  logic      we_s2;
  logic      in_frame_s2;
  logic      last_s2;
  pxl_addr_t addr_s2;
  bin_idx_t  bin_s2;

  assign end_pxl = (cnt_pxl == PXL_ADDR_W'(IMG_PXLS - 1));
  assign end_ln  = (col == col_t'(`IMG_COLS - 1));

  // busy flag and raster counters
  // a start pulse is only taken while idle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy    <= 1'b0;
      cnt_pxl <= '0;
      col     <= '0;
      row     <= '0;
    end else if (busy) begin
      if (end_pxl) begin
        busy    <= 1'b0;
        cnt_pxl <= '0;
        col     <= '0;
        row     <= '0;
      end else begin
        cnt_pxl <= cnt_pxl + 1'b1;
        if (end_ln) begin
          col <= '0;
          row <= row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end else if (new_frame_i) begin
      busy <= 1'b1;
    end
  end

  // inner frame window
  assign in_frame_s0 = busy &&
                       (col >= col_t'(`BORDER_COLS)) &&
                       (col <  col_t'(`IMG_COLS - `BORDER_COLS)) &&
                       (row >= row_t'(`BORDER_ROWS)) &&
                       (row <  row_t'(`IMG_ROWS - `BORDER_ROWS));
  assign last_s0     = busy && end_pxl;

  // bin is the inner column divided by the bin width
  // outside the window the value is don't care
  assign col_inner = col - col_t'(`BORDER_COLS);
  assign bin_s0    = col_inner[BIN_SHIFT +: BIN_IDX_W];

  // control flags through the two stages
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_s1    <= 1'b0;
      in_frame_s1 <= 1'b0;
      last_s1     <= 1'b0;
      we_s2       <= 1'b0;
      in_frame_s2 <= 1'b0;
      last_s2     <= 1'b0;
    end else begin
      valid_s1    <= busy;
      in_frame_s1 <= in_frame_s0;
      last_s1     <= last_s0;
      we_s2       <= valid_s1;
      in_frame_s2 <= in_frame_s1;
      last_s2     <= last_s1;
    end
  end

  // address and bin only matter while the flags above are set
  always_ff @(posedge clk) begin
    addr_s1 <= cnt_pxl;
    bin_s1  <= bin_s0;
    addr_s2 <= addr_s1;
    bin_s2  <= bin_s1;
  end

  assign orig_addr_o = cnt_pxl;
  assign pxl_valid_o = valid_s1;
  assign proc_addr_o = addr_s2;
  assign proc_we_o   = we_s2;
  assign in_frame_o  = in_frame_s2;
  assign bin_idx_o   = bin_s2;
  assign last_pxl_o  = last_s2;

  // writes never leave the buffer
  a_we_in_range: assert property (@(posedge clk) disable iff (rst)
    proc_we_o |-> (proc_addr_o < PXL_ADDR_W'(IMG_PXLS)));

endmodule

`default_nettype wire

/* color_classifier.sv */
// color classifier
// steps the filter mode on each rising edge of the control input
// and registers a pass decision with its pixel, one cycle after
// the read data arrives
`timescale 1ns/1ps
`include "color_proc_defs.svh"
`default_nettype none

module color_classifier import color_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        proc_ctrl_i,
  input  pixel_t      orig_pxl_i,
  input  logic        pxl_valid_i,
  output color_mode_e mode_o,
  output logic        pass_o,
  output pixel_t      pxl_held_o
);

  logic        ctrl_s1;
  logic        ctrl_s2;
  logic        ctrl_rise;
  color_mode_e mode_next;
  comp_t       red;
  comp_t       grn;
  comp_t       blu;
  logic [2:0]  high_rgb;
  logic        match;

  // control input comes from a button or another clock domain
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl_s1 <= 1'b0;
      ctrl_s2 <= 1'b0;
    end else begin
      ctrl_s1 <= proc_ctrl_i;
      ctrl_s2 <= ctrl_s1;
    end
  end

  assign ctrl_rise = ctrl_s1 & ~ctrl_s2;

  // fixed mode cycle
  always_comb begin
    unique case (mode_o)
      MODE_NONE:    mode_next = MODE_RED;
      MODE_RED:     mode_next = MODE_GREEN;
      MODE_GREEN:   mode_next = MODE_BLUE;
      MODE_BLUE:    mode_next = MODE_YELLOW;
      MODE_YELLOW:  mode_next = MODE_MAGENTA;
      MODE_MAGENTA: mode_next = MODE_CYAN;
      MODE_CYAN:    mode_next = MODE_WHITE;
      MODE_WHITE:   mode_next = MODE_NONE;
      default:      mode_next = MODE_NONE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mode_o <= MODE_NONE;
    end else if (ctrl_rise) begin
      mode_o <= mode_next;
    end
  end

  // split the buffer word into components
  assign red = orig_pxl_i[3*`COMP_BITS-1 -: `COMP_BITS];
  assign grn = orig_pxl_i[2*`COMP_BITS-1 -: `COMP_BITS];
  assign blu = orig_pxl_i[`COMP_BITS-1 -: `COMP_BITS];

  // level is the top two bits, high from level 2 up
  assign high_rgb = {(red[`COMP_BITS-1 -: 2] >= 2'd2),
                     (grn[`COMP_BITS-1 -: 2] >= 2'd2),
                     (blu[`COMP_BITS-1 -: 2] >= 2'd2)};

  // the high set has to equal the mode bits exactly
  assign match = (mode_o == MODE_NONE) || (high_rgb == mode_o);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pass_o <= 1'b0;
    end else begin
      pass_o <= pxl_valid_i && match;
    end
  end

  // held pixel goes to the write port next cycle
  always_ff @(posedge clk) begin
    if (pxl_valid_i) begin
      pxl_held_o <= orig_pxl_i;
    end
  end

  a_mode_legal: assert property (@(posedge clk) disable iff (rst)
    mode_o inside {MODE_NONE, MODE_RED, MODE_GREEN, MODE_BLUE,
                   MODE_YELLOW, MODE_MAGENTA, MODE_CYAN, MODE_WHITE});

endmodule

`default_nettype wire

/* histogram_accum.sv */
// spatial histogram accumulator
// counts passing inner-frame pixels per 16-column bin and in total,
// publishes the counts with a done pulse once the last pixel is in
// and starts the next frame from zero
`timescale 1ns/1ps
`default_nettype none

module histogram_accum import frame_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       pass_i,
  input  logic       in_frame_i,
  input  bin_idx_t   bin_idx_i,
  input  logic       last_pxl_i,
  input  logic       write_i,
  output hist_t      hist_o,
  output total_cnt_t total_o,
  output logic       frame_done_o
);

  hist_t      run_bins;
  hist_t      bins_next;
  total_cnt_t run_total;
  total_cnt_t total_next;
  logic       count_en;
  logic       frame_end;

  assign count_en  = write_i && in_frame_i && pass_i;
  assign frame_end = write_i && last_pxl_i;

  // running counts with the current pixel added
  always_comb begin
    bins_next  = run_bins;
    total_next = run_total;
    if (count_en) begin
      bins_next[bin_idx_i] = run_bins[bin_idx_i] + 1'b1;
      total_next           = run_total + 1'b1;
    end
  end

  // running counters
  // cleared at frame end so the next frame starts from zero
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_bins  <= '0;
      run_total <= '0;
    end else if (frame_end) begin
      run_bins  <= '0;
      run_total <= '0;
    end else begin
      run_bins  <= bins_next;
      run_total <= total_next;
    end
  end

  // published counts
  // snapshot includes the last pixel of the frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hist_o       <= '0;
      total_o      <= '0;
      frame_done_o <= 1'b0;
    end else begin
      frame_done_o <= frame_end;
      if (frame_end) begin
        hist_o  <= bins_next;
        total_o <= total_next;
      end
    end
  end

  // one pulse per frame, frames are far longer than a cycle
  a_done_single: assert property (@(posedge clk) disable iff (rst)
    frame_done_o |=> !frame_done_o);

endmodule

`default_nettype wire

/* color_proc.sv */
// color filter and spatial histogram engine, top level
// scanner reads the source buffer, classifier filters each pixel,
// the processed buffer gets the pixel or black and the histogram
// of passing inner-frame pixels comes out per bin and in total
`timescale 1ns/1ps
`default_nettype none

module color_proc import color_pkg::*, frame_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        new_frame_i,
  input  logic        proc_ctrl_i,
  input  pixel_t      orig_pxl_i,
  output pxl_addr_t   orig_addr_o,
  output pxl_addr_t   proc_addr_o,
  output logic        proc_we_o,
  output pixel_t      proc_pxl_o,
  output color_mode_e mode_o,
  output logic        frame_done_o,
  output total_cnt_t  colorpxls_o,
  output bin_cnt_t    hist_bin0_o,
  output bin_cnt_t    hist_bin1_o,
  output bin_cnt_t    hist_bin2_o,
  output bin_cnt_t    hist_bin3_o,
  output bin_cnt_t    hist_bin4_o,
  output bin_cnt_t    hist_bin5_o,
  output bin_cnt_t    hist_bin6_o,
  output bin_cnt_t    hist_bin7_o
);

  logic     pxl_valid;
  logic     pass;
  pixel_t   pxl_held;
  logic     in_frame;
  bin_idx_t bin_idx;
  logic     last_pxl;
  hist_t    hist;

  frame_scanner u_scanner (
    .clk         (clk),
    .rst         (rst),
    .new_frame_i (new_frame_i),
    .orig_addr_o (orig_addr_o),
    .pxl_valid_o (pxl_valid),
    .proc_addr_o (proc_addr_o),
    .proc_we_o   (proc_we_o),
    .in_frame_o  (in_frame),
    .bin_idx_o   (bin_idx),
    .last_pxl_o  (last_pxl)
  );

  color_classifier u_classifier (
    .clk         (clk),
    .rst         (rst),
    .proc_ctrl_i (proc_ctrl_i),
    .orig_pxl_i  (orig_pxl_i),
    .pxl_valid_i (pxl_valid),
    .mode_o      (mode_o),
    .pass_o      (pass),
    .pxl_held_o  (pxl_held)
  );

  histogram_accum u_hist (
    .clk          (clk),
    .rst          (rst),
    .pass_i       (pass),
    .in_frame_i   (in_frame),
    .bin_idx_i    (bin_idx),
    .last_pxl_i   (last_pxl),
    .write_i      (proc_we_o),
    .hist_o       (hist),
    .total_o      (colorpxls_o),
    .frame_done_o (frame_done_o)
  );

  // rejected pixels are written as black
  assign proc_pxl_o = pass ? pxl_held : '0;

  // bin 0 is the leftmost
  assign hist_bin0_o = hist[0];
  assign hist_bin1_o = hist[1];
  assign hist_bin2_o = hist[2];
  assign hist_bin3_o = hist[3];
  assign hist_bin4_o = hist[4];
  assign hist_bin5_o = hist[5];
  assign hist_bin6_o = hist[6];
  assign hist_bin7_o = hist[7];

endmodule

`default_nettype wire

/* tb_color_model.svh */
// testbench reference model for the color filter engine
// random pixel source, pass rule, mode order and bin geometry
`ifndef TB_COLOR_MODEL_SVH
`define TB_COLOR_MODEL_SVH

// 32-bit linear congruential step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

// source pixel from the upper state bits
// about one in four is a pure color, each component full or off
function automatic logic [11:0] make_pixel(input logic [31:0] s);
  logic [2:0] pick;
  pick = s[18:16];
  if (s[31:30] == 2'b00) begin
    return {{4{pick[2]}}, {4{pick[1]}}, {4{pick[0]}}};
  end
  return s[27:16];
endfunction

// level is the top two bits, high from level 2 up
function automatic logic is_high(input logic [3:0] c);
  return (c[3:2] >= 2'd2);
endfunction

// mode none passes all, others need exactly the named components high
function automatic logic pixel_passes(input logic [11:0] p, input logic [2:0] mode);
  logic [2:0] hi;
  hi = {is_high(p[11:8]), is_high(p[7:4]), is_high(p[3:0])};
  if (mode == 3'b000) begin
    return 1'b1;
  end
  return (hi == mode);
endfunction

// order the control input steps through, mode bits are R, G, B
function automatic logic [2:0] mode_after(input logic [2:0] mode);
  case (mode)
    3'b000:  return 3'b100;
    3'b100:  return 3'b010;
    3'b010:  return 3'b001;
    3'b001:  return 3'b110;
    3'b110:  return 3'b101;
    3'b101:  return 3'b011;
    3'b011:  return 3'b111;
    default: return 3'b000;
  endcase
endfunction

// inner frame test on a raster address
function automatic logic in_inner(input int addr);
  int col;
  int row;
  col = addr % `IMG_COLS;
  row = addr / `IMG_COLS;
  return (col >= `BORDER_COLS) && (col < `IMG_COLS - `BORDER_COLS) &&
         (row >= `BORDER_ROWS) && (row < `IMG_ROWS - `BORDER_ROWS);
endfunction

// 16-column bin, 0 at the left edge of the inner frame
function automatic int bin_of(input int addr);
  return (addr % `IMG_COLS - `BORDER_COLS) /
         ((`IMG_COLS - 2 * `BORDER_COLS) / `HIST_BINS);
endfunction

`endif

/* tb_color_proc.sv */
// testbench for the color filter and histogram engine
// one random frame per filter mode, checks write-back, counts,
// done timing, ignored starts and mode stepping against a model
`timescale 1ns/1ps
`include "color_proc_defs.svh"
`default_nettype none

module tb_color_proc;

  localparam int IMG_PXLS   = `IMG_COLS * `IMG_ROWS;
  localparam int NUM_FRAMES = 8;
  // one scan plus mode stepping and settling per frame and a third spare
  localparam int FRAME_BUDGET   = IMG_PXLS + 64;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_BUDGET * 4 / 3;

  logic        clk;
  logic        rst;
  logic        new_frame_i;
  logic        proc_ctrl_i;
  logic [11:0] orig_pxl_i;
  logic [14:0] orig_addr_o;
  logic [14:0] proc_addr_o;
  logic        proc_we_o;
  logic [11:0] proc_pxl_o;
  logic [2:0]  mode_o;
  logic        frame_done_o;
  logic [13:0] colorpxls_o;
  logic [10:0] hist_bin [`HIST_BINS];

  // source buffer and what the DUT wrote back
  logic [11:0] img [IMG_PXLS];
  logic [11:0] wr_img [IMG_PXLS];
  logic [14:0] rd_addr;
  logic [31:0] seed;
  logic [2:0]  cur_mode;
  int          exp_bins [`HIST_BINS];
  int          exp_total;
  int          cycles = 0;
  int          errors_value;
  int          errors_other;
  int          wr_cnt;
  int          done_cnt;
  int          last_addr_cyc;
  int          rd_exp;
  logic        rd_active;

  `include "tb_color_model.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  color_proc UUT (
    .clk          (clk),
    .rst          (rst),
    .new_frame_i  (new_frame_i),
    .proc_ctrl_i  (proc_ctrl_i),
    .orig_pxl_i   (orig_pxl_i),
    .orig_addr_o  (orig_addr_o),
    .proc_addr_o  (proc_addr_o),
    .proc_we_o    (proc_we_o),
    .proc_pxl_o   (proc_pxl_o),
    .mode_o       (mode_o),
    .frame_done_o (frame_done_o),
    .colorpxls_o  (colorpxls_o),
    .hist_bin0_o  (hist_bin[0]),
    .hist_bin1_o  (hist_bin[1]),
    .hist_bin2_o  (hist_bin[2]),
    .hist_bin3_o  (hist_bin[3]),
    .hist_bin4_o  (hist_bin[4]),
    .hist_bin5_o  (hist_bin[5]),
    .hist_bin6_o  (hist_bin[6]),
    .hist_bin7_o  (hist_bin[7])
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      errors_value = errors_value + 1;
      $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // read port takes the address mid cycle and answers after the next edge
  always @(negedge clk) rd_addr = orig_addr_o;

  always @(posedge clk) begin
    #1 orig_pxl_i = img[rd_addr];
  end

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a frame never finished", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // read port, write port and done monitor sample mid cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (orig_addr_o == 15'(IMG_PXLS - 1)) last_addr_cyc = cycles;
      // reads walk the buffer from address 0 without gaps
      if (rd_active) begin
        compare_value("orig_addr_o", orig_addr_o, rd_exp);
        rd_exp = rd_exp + 1;
        if (rd_exp == IMG_PXLS) begin
          rd_active = 1'b0;
        end
      end
      // writes have to come in raster order from address 0
      if (proc_we_o) begin
        compare_value("proc_addr_o", proc_addr_o, wr_cnt);
        wr_img[proc_addr_o] = proc_pxl_o;
        wr_cnt = wr_cnt + 1;
      end
      if (frame_done_o) begin
        done_cnt = done_cnt + 1;
        assert (cycles == last_addr_cyc + 3) else begin
          errors_other = errors_other + 1;
          $display("frame_done_o came %0d cycles after the last read address, not 3",
                   cycles - last_addr_cyc);
        end
        for (int b = 0; b < `HIST_BINS; b++) begin
          compare_value($sformatf("hist_bin%0d_o", b), hist_bin[b], exp_bins[b]);
        end
        compare_value("colorpxls_o", colorpxls_o, exp_total);
      end
    end
  end

  // new random image and its expected counts under the current mode
  task automatic prepare_frame();
    exp_total = 0;
    for (int b = 0; b < `HIST_BINS; b++) exp_bins[b] = 0;
    for (int a = 0; a < IMG_PXLS; a++) begin
      seed   = lcg_next(seed);
      img[a] = make_pixel(seed);
      if (in_inner(a) && pixel_passes(img[a], cur_mode)) begin
        exp_bins[bin_of(a)] = exp_bins[bin_of(a)] + 1;
        exp_total           = exp_total + 1;
      end
    end
  endtask

  task automatic check_writes();
    logic [11:0] exp_pxl;
    compare_value("write count", wr_cnt, IMG_PXLS);
    for (int a = 0; a < IMG_PXLS; a++) begin
      exp_pxl = pixel_passes(img[a], cur_mode) ? img[a] : 12'h000;
      compare_value($sformatf("proc_pxl_o at %0d", a), wr_img[a], exp_pxl);
    end
  endtask

  task automatic run_frame();
    prepare_frame();
    wr_cnt   = 0;
    done_cnt = 0;
    @(posedge clk);
    #1 new_frame_i = 1'b1;
    @(posedge clk);
    #1 new_frame_i = 1'b0;
    // start was taken at this edge, address 0 is up in this cycle
    rd_exp    = 0;
    rd_active = 1'b1;
    // a start in the middle of the scan must not restart it
    repeat (IMG_PXLS / 2) @(posedge clk);
    #1 new_frame_i = 1'b1;
    @(posedge clk);
    #1 new_frame_i = 1'b0;
    while (done_cnt == 0) @(posedge clk);
    repeat (8) @(posedge clk);
    @(negedge clk);
    assert (done_cnt == 1) else begin
      errors_other = errors_other + 1;
      $display("frame_done_o pulsed %0d times in one frame", done_cnt);
    end
    check_writes();
    // published counts stay until the next done pulse
    compare_value("colorpxls_o held", colorpxls_o, exp_total);
    for (int b = 0; b < `HIST_BINS; b++) begin
      compare_value($sformatf("hist_bin%0d_o held", b), hist_bin[b], exp_bins[b]);
    end
  endtask

  // one rising edge on the control input while idle
  task automatic step_mode();
    cur_mode = mode_after(cur_mode);
    @(posedge clk);
    #1 proc_ctrl_i = 1'b1;
    repeat (8) @(posedge clk);
    #1 proc_ctrl_i = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    compare_value("mode_o", mode_o, cur_mode);
  endtask

  initial begin
    rst           = 1'b1;
    new_frame_i   = 1'b0;
    proc_ctrl_i   = 1'b0;
    orig_pxl_i    = '0;
    rd_addr       = '0;
    seed          = 32'd18707;
    cur_mode      = 3'b000;
    errors_value  = 0;
    errors_other  = 0;
    wr_cnt        = 0;
    done_cnt      = 0;
    last_addr_cyc = 0;
    rd_exp        = 0;
    rd_active     = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    compare_value("proc_we_o", proc_we_o, 0);
    compare_value("frame_done_o", frame_done_o, 0);
    compare_value("mode_o", mode_o, 0);
    compare_value("colorpxls_o", colorpxls_o, 0);
    for (int b = 0; b < `HIST_BINS; b++) begin
      compare_value($sformatf("hist_bin%0d_o", b), hist_bin[b], 0);
    end
    // mode none first, then one step per frame up to white
    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (f > 0) step_mode();
      run_frame();
    end
    // white wraps back to none
    step_mode();
    $display("errors: %0d wrong values, %0d other", errors_value, errors_other);
    if (errors_value + errors_other == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* color_proc.f */
+incdir+.
color_pkg.sv
frame_pkg.sv
frame_scanner.sv
color_classifier.sv
histogram_accum.sv
color_proc.sv
tb_color_proc.sv

/* run_sim.sh */
#!/bin/sh
# build the color_proc testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f color_proc.f --top-module tb_color_proc -o sim_color_proc

./obj_dir/sim_color_proc | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  echo "run_sim: simulation passed"
else
  echo "run_sim: simulation failed"
  exit 1
fi
